// ==== flist.f ====
+incdir+.
cpu_pkg.sv
register_file.sv
instruction_decode.sv
control_fsm.sv
datapath.sv
address_unit.sv
cpu.sv
tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f flist.f \
   --Mdir obj_dir -o tb_cpu_sim > build.log 2>&1 \
   && ./obj_dir/tb_cpu_sim > sim.log 2>&1 \
   && grep -q "^Test completed successfully$" sim.log \
   && echo "PASS" \
   || { echo "FAIL, see build.log and sim.log"; exit 1; }

// ==== cpu_model.svh ====
// Instruction-level CPU reference model and random program generator for the testbench
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

int gen_ptr;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
   logic [31:0] x;
   x = s;
   x ^= x << 13;
   x ^= x >> 17;
   x ^= x << 5;
   return x;
endfunction

function automatic logic [31:0] draw_random();
   rng_state = xorshift32(rng_state);
   return rng_state;
endfunction

function automatic reg_idx_t pick_reg(input int limit);
   return reg_idx_t'(draw_random() % limit);
endfunction

// Low byte carries rd/rm, rd/imm5 or imm8 depending on the instruction
function automatic word_t encode(input opcode_t opc, input logic [1:0] op,
                                 input reg_idx_t rn, input logic [7:0] low);
   return {opc, op, rn, low};
endfunction

task automatic emit(input word_t w);
   init_mem[gen_ptr] = w;
   gen_ptr++;
endtask

function automatic word_t random_alu_instr();
   logic [31:0] r;
   reg_idx_t rn;
   reg_idx_t rd;
   reg_idx_t rm;
   word_t w;
   r = draw_random();
   rn = pick_reg(7);
   rd = pick_reg(7);
   rm = pick_reg(7);
   case (r % 4)
      0: w = encode(OPC_ALU, ALU_ADD, rn, {rd, 2'b00, rm});
      1: w = encode(OPC_ALU, ALU_AND, rn, {rd, 2'b00, rm});
      2: w = encode(OPC_ALU, ALU_NOT, rn, {rd, 2'b00, rm});
      default: w = encode(OPC_MOVE, MOVE_OP_REG, 3'd0, {rd, 2'b00, rm});
   endcase
   return w;
endfunction

// Code fills words below DATA_BASE and random data the rest of the program image
task automatic build_program();
   int i;
   reg_idx_t ra;
   reg_idx_t rb;
   reg_idx_t rt;
   reg_idx_t cond;
   logic [1:0] link_op;
   logic [7:0] target;
   gen_ptr = 0;
   for (i = 0; i < MEM_WORDS; i++) begin
      if (i >= PROG_LEN) begin
         init_mem[i] = word_t'(i) ^ 16'hA5C3;
      end else if (i >= DATA_BASE) begin
         init_mem[i] = word_t'(draw_random());
      end else begin
         init_mem[i] = encode(OPC_HALT, 2'd0, 3'd0, 8'd0);
      end
   end
   for (i = 0; i < 7; i++) begin
      emit(encode(OPC_MOVE, MOVE_OP_IMM, reg_idx_t'(i), 8'(draw_random())));
   end
   repeat (2) emit(random_alu_instr());
   // Compare then skip one instruction when the condition holds
   repeat (2) begin
      ra = pick_reg(7);
      rb = (draw_random() % 4 == 0) ? ra : pick_reg(7);
      cond = (draw_random() % 2 == 0) ? COND_EQ : COND_NE;
      emit(encode(OPC_ALU, ALU_CMP, ra, {3'd0, 2'b00, rb}));
      emit(encode(OPC_BRANCH, 2'd0, cond, 8'd1));
      emit(random_alu_instr());
   end
   emit(encode(OPC_LINK, LINK_OP_REL, 3'd7, 8'd1));
   emit(random_alu_instr());
   rt = pick_reg(6);
   target = 8'(gen_ptr + 3);
   link_op = (draw_random() % 2 == 0) ? LINK_OP_REG : LINK_OP_REG_LINK;
   emit(encode(OPC_MOVE, MOVE_OP_IMM, rt, target));
   emit(encode(OPC_LINK, link_op, pick_reg(6), {rt, 5'd0}));
   emit(random_alu_instr());
   // R6 points into the middle of the data area
   emit(encode(OPC_MOVE, MOVE_OP_IMM, 3'd6, 8'(DATA_BASE + 16)));
   emit(encode(OPC_LOAD, 2'd0, 3'd6, {pick_reg(6), 5'(draw_random())}));
   emit(encode(OPC_STORE, 2'd0, 3'd6, {pick_reg(7), 5'(draw_random())}));
   for (i = 0; i < 8; i++) begin
      emit(encode(OPC_STORE, 2'd0, 3'd6, {reg_idx_t'(i), 5'(i - 16)}));
   end
   emit(encode(OPC_HALT, 2'd0, 3'd0, 8'd0));
endtask

task automatic run_model();
   word_t regs_m [8];
   word_t mem_m [MEM_WORDS];
   logic [ADDR_W-1:0] pc_m;
   logic [ADDR_W-1:0] ea;
   word_t ir;
   word_t target;
   word_t sx5;
   word_t sx8;
   reg_idx_t rn;
   reg_idx_t rd;
   reg_idx_t rm;
   logic [1:0] op;
   logic zero_m;
   logic halted;
   int steps;
   exp_addr.delete();
   exp_data.delete();
   mem_m = init_mem;
   foreach (regs_m[i]) regs_m[i] = '0;
   pc_m = '0;
   zero_m = 1'b0;
   halted = 1'b0;
   steps = 0;
   while (!halted && steps < PROG_LEN) begin
      ir = mem_m[pc_m];
      pc_m = pc_m + 1;
      steps++;
      op = ir[OP_MSB:OP_LSB];
      rn = ir[RN_MSB:RN_LSB];
      rd = ir[RD_MSB:RD_LSB];
      rm = ir[RM_MSB:RM_LSB];
      sx5 = {{11{ir[4]}}, ir[4:0]};
      sx8 = {{8{ir[7]}}, ir[7:0]};
      case (opcode_t'(ir[OPC_MSB:OPC_LSB]))
         OPC_ALU: begin
            case (op)
               2'd0: regs_m[rd] = regs_m[rn] + regs_m[rm];
               2'd1: zero_m = (regs_m[rn] == regs_m[rm]);
               2'd2: regs_m[rd] = regs_m[rn] & regs_m[rm];
               default: regs_m[rd] = ~regs_m[rm];
            endcase
         end
         OPC_MOVE: begin
            if (op == MOVE_OP_REG) begin
               regs_m[rd] = regs_m[rm];
            end else begin
               regs_m[rn] = sx8;
            end
         end
         OPC_LOAD: begin
            ea = ADDR_W'(regs_m[rn] + sx5);
            regs_m[rd] = mem_m[ea];
         end
         OPC_STORE: begin
            ea = ADDR_W'(regs_m[rn] + sx5);
            mem_m[ea] = regs_m[rd];
            exp_addr.push_back(ea);
            exp_data.push_back(regs_m[rd]);
         end
         OPC_BRANCH: begin
            if (rn == COND_ALWAYS || (rn == COND_EQ && zero_m) || (rn == COND_NE && !zero_m)) begin
               pc_m = pc_m + ADDR_W'(sx8);
            end
         end
         OPC_LINK: begin
            // Target is read before the link register is written
            target = regs_m[rd];
            if (op == LINK_OP_REL) begin
               regs_m[rn] = word_t'(pc_m);
               pc_m = pc_m + ADDR_W'(sx8);
            end else begin
               if (op == LINK_OP_REG_LINK) begin
                  regs_m[rn] = word_t'(pc_m);
               end
               pc_m = ADDR_W'(target);
            end
         end
         default: halted = 1'b1;
      endcase
   end
endtask

`endif

// ==== tb_cpu.sv ====
// Testbench for the multicycle CPU with a synchronous memory and an instruction-level model
module tb_cpu import cpu_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int ADDR_W = 9;
   localparam int MEM_WORDS = 2**ADDR_W;
   localparam int PROG_LEN = 64;
   localparam int DATA_BASE = 32;
   localparam int N_PROGS = 8;
   localparam int HALT_CYCLES = 20;
   localparam int TIMEOUT_CYCLES = N_PROGS * (PROG_LEN * 6 + 50);

   logic              clk;
   logic              reset;
   word_t             read_data;
   mem_cmd_t          mem_cmd;
   logic [ADDR_W-1:0] mem_addr;
   word_t             write_data;
   logic              halt;

   word_t             mem [MEM_WORDS];
   word_t             init_mem [MEM_WORDS];
   logic [ADDR_W-1:0] exp_addr [$];
   word_t             exp_data [$];
   logic [31:0]       rng_state;
   int                store_idx;
   int                errors;
   int                checks;
   int                prog_num;
   int                cycle_count;

   // Values seen in the middle of each cycle
   logic [ADDR_W-1:0] cyc_addr;
   mem_cmd_t          cyc_cmd;
   word_t             cyc_wdata;
   logic              cyc_halt;

   `include "cpu_model.svh"

   cpu #(.ADDR_W(ADDR_W)) cpu_inst (
      .clk(clk), .reset(reset), .read_data(read_data), .mem_cmd(mem_cmd),
      .mem_addr(mem_addr), .write_data(write_data), .halt(halt)
   );

   always #2 clk = ~clk;

   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %s: got 0x%h expected 0x%h (program %0d)", name, got, exp, prog_num);
      end
   endtask

   task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                             input logic [ADDR_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %s: got 0x%h expected 0x%h (program %0d)", name, got, exp, prog_num);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %s: got 0x%h expected 0x%h (program %0d)", name, got, exp, prog_num);
      end
   endtask

   task automatic check_cmd(input string name, input mem_cmd_t got, input mem_cmd_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %s: got 0x%h expected 0x%h (program %0d)", name, got, exp, prog_num);
      end
   endtask

   always @(negedge clk) begin
      cyc_addr = mem_addr;
      cyc_cmd = mem_cmd;
      cyc_wdata = write_data;
      cyc_halt = halt;
   end

   // Synchronous memory whose read data follows the address of the previous cycle
   always @(posedge clk) begin
      #1;
      read_data = mem[cyc_addr];
      if (cyc_cmd == MEM_WRITE) begin
         if (cyc_halt) begin
            errors++;
            $display("Write to address 0x%h while the core is halted", cyc_addr);
         end else if (store_idx >= exp_addr.size()) begin
            errors++;
            $display("Unexpected extra store to address 0x%h in program %0d", cyc_addr, prog_num);
         end else begin
            check_addr("mem_addr", cyc_addr, exp_addr[store_idx]);
            check_word("write_data", cyc_wdata, exp_data[store_idx]);
         end
         store_idx++;
         mem[cyc_addr] = cyc_wdata;
      end
   end

   task automatic run_program();
      @(posedge clk);
      #1;
      reset = 1'b1;
      build_program();
      run_model();
      @(negedge clk);
      mem = init_mem;
      store_idx = 0;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      check_bit("halt", halt, 1'b0);
      check_cmd("mem_cmd", mem_cmd, MEM_READ);
      check_addr("mem_addr", mem_addr, '0);
      while (halt !== 1'b1) @(negedge clk);
      if (store_idx != exp_addr.size()) begin
         errors++;
         $display("Program %0d halted after %0d stores, model expects %0d",
                  prog_num, store_idx, exp_addr.size());
      end
      repeat (HALT_CYCLES) @(negedge clk);
      check_bit("halt", halt, 1'b1);
   endtask

   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout after %0d cycles in program %0d", cycle_count, prog_num);
      $display("Test failed");
      $finish;
   end

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      read_data = '0;
      cyc_addr = '0;
      cyc_cmd = MEM_READ;
      cyc_wdata = '0;
      cyc_halt = 1'b0;
      rng_state = 32'd31;
      errors = 0;
      checks = 0;
      store_idx = 0;
      for (prog_num = 0; prog_num < N_PROGS; prog_num++) begin
         run_program();
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== cpu.sv ====
// CPU top level connecting decode, control, datapath and address generation
module cpu import cpu_pkg::*; #(
   parameter int ADDR_W = ADDR_W_DEFAULT
) (
   input  logic              clk,
   input  logic              reset,
   input  word_t             read_data,
   output mem_cmd_t          mem_cmd,
   output logic [ADDR_W-1:0] mem_addr,
   output word_t             write_data,
   output logic              halt
);

   opcode_t           opcode;
   logic [1:0]        op;
   alu_op_t           alu_op;
   reg_idx_t          rn;
   reg_idx_t          rd;
   reg_idx_t          rm;
   word_t             sximm5;
   word_t             sximm8;
   logic              take_branch;
   logic              load_ir;
   logic              load_pc;
   logic              reset_pc;
   pc_src_t           pc_src;
   logic              load_addr;
   logic              addr_sel;
   reg_idx_t          read_a;
   reg_idx_t          read_b;
   reg_idx_t          write_num;
   logic              reg_write;
   logic              load_status;
   logic              asel;
   logic              bsel;
   wb_sel_t           wb_sel;
   logic              zero;
   logic [ADDR_W-1:0] pc;

   instruction_decode decode_inst (
      .clk(clk), .load_ir(load_ir), .read_data(read_data), .zero(zero),
      .opcode(opcode), .op(op), .alu_op(alu_op), .rn(rn), .rd(rd), .rm(rm),
      .sximm5(sximm5), .sximm8(sximm8), .take_branch(take_branch)
   );

   control_fsm control_inst (
      .clk(clk), .reset(reset), .opcode(opcode), .op(op), .rn(rn), .rd(rd), .rm(rm),
      .take_branch(take_branch), .load_ir(load_ir), .load_pc(load_pc),
      .reset_pc(reset_pc), .pc_src(pc_src), .load_addr(load_addr), .addr_sel(addr_sel),
      .read_a(read_a), .read_b(read_b), .write_num(write_num), .reg_write(reg_write),
      .load_status(load_status), .asel(asel), .bsel(bsel), .wb_sel(wb_sel),
      .mem_cmd(mem_cmd), .halt(halt)
   );

   datapath #(.ADDR_W(ADDR_W)) datapath_inst (
      .clk(clk), .read_a(read_a), .read_b(read_b), .write_num(write_num),
      .reg_write(reg_write), .load_status(load_status), .asel(asel), .bsel(bsel),
      .wb_sel(wb_sel), .alu_op(alu_op), .sximm5(sximm5), .sximm8(sximm8), .pc(pc),
      .read_data(read_data), .result(write_data), .zero(zero)
   );

   address_unit #(.ADDR_W(ADDR_W)) address_inst (
      .clk(clk), .load_pc(load_pc), .reset_pc(reset_pc), .pc_src(pc_src),
      .sximm8(sximm8), .target(write_data), .load_addr(load_addr), .addr_sel(addr_sel),
      .pc(pc), .mem_addr(mem_addr)
   );

endmodule

// ==== address_unit.sv ====
// Program counter, data address register and memory address select
module address_unit import cpu_pkg::*; #(
   parameter int ADDR_W = ADDR_W_DEFAULT
) (
   input  logic              clk,
   input  logic              load_pc,
   input  logic              reset_pc,
   input  pc_src_t           pc_src,
   input  word_t             sximm8,
   input  word_t             target,
   input  logic              load_addr,
   input  logic              addr_sel,
   output logic [ADDR_W-1:0] pc,
   output logic [ADDR_W-1:0] mem_addr
);

   logic [ADDR_W-1:0] next_pc;
   logic [ADDR_W-1:0] data_addr;

   // Relative branches count from the already incremented pc
   always_comb begin
      case (pc_src)
         PC_INC:  next_pc = pc + 1'b1;
         PC_HOLD: next_pc = pc;
         PC_REL:  next_pc = pc + sximm8[ADDR_W-1:0];
         default: next_pc = target[ADDR_W-1:0];
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_pc) begin
         pc <= '0;
      end else if (load_pc) begin
         pc <= next_pc;
      end
      if (load_addr) begin
         data_addr <= target[ADDR_W-1:0];
      end
   end

   assign mem_addr = addr_sel ? pc : data_addr;

endmodule

// ==== datapath.sv ====
// Operand registers, ALU, zero flag, result register and register write-back
module datapath import cpu_pkg::*; #(
   parameter int ADDR_W = ADDR_W_DEFAULT
) (
   input  logic              clk,
   input  reg_idx_t          read_a,
   input  reg_idx_t          read_b,
   input  reg_idx_t          write_num,
   input  logic              reg_write,
   input  logic              load_status,
   input  logic              asel,
   input  logic              bsel,
   input  wb_sel_t           wb_sel,
   input  alu_op_t           alu_op,
   input  word_t             sximm5,
   input  word_t             sximm8,
   input  logic [ADDR_W-1:0] pc,
   input  word_t             read_data,
   output word_t             result,
   output logic              zero
);

   word_t data_a;
   word_t data_b;
   word_t a_reg;
   word_t b_reg;
   word_t ain;
   word_t bin;
   word_t alu_out;
   word_t wb_data;

   register_file #(.DATA_W_P(DATA_W)) regs_inst (
      .clk(clk), .write(reg_write), .write_num(write_num), .write_data(wb_data),
      .read_a(read_a), .read_b(read_b), .data_a(data_a), .data_b(data_b)
   );

   always_ff @(posedge clk) begin
      a_reg <= data_a;
      b_reg <= data_b;
      result <= alu_out;
      if (load_status) begin
         zero <= (result == '0);
      end
   end

   // asel forces a zero A input for moves and register pass-through
   assign ain = asel ? '0 : a_reg;
   assign bin = bsel ? sximm5 : b_reg;

   always_comb begin
      case (alu_op)
         ALU_ADD: alu_out = ain + bin;
         ALU_CMP: alu_out = ain - bin;
         ALU_AND: alu_out = ain & bin;
         default: alu_out = ~bin;
      endcase
   end

   always_comb begin
      case (wb_sel)
         WB_ALU:  wb_data = result;
         WB_PC:   wb_data = word_t'(pc);
         WB_IMM:  wb_data = sximm8;
         default: wb_data = read_data;
      endcase
   end

   a_write_num_known: assert property (@(posedge clk) reg_write |-> !$isunknown(write_num));

endmodule

// ==== control_fsm.sv ====
// Multicycle controller sequencing fetch, decode and execute for the CPU
module control_fsm import cpu_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  opcode_t    opcode,
   input  logic [1:0] op,
   input  reg_idx_t   rn,
   input  reg_idx_t   rd,
   input  reg_idx_t   rm,
   input  logic       take_branch,
   output logic       load_ir,
   output logic       load_pc,
   output logic       reset_pc,
   output pc_src_t    pc_src,
   output logic       load_addr,
   output logic       addr_sel,
   output reg_idx_t   read_a,
   output reg_idx_t   read_b,
   output reg_idx_t   write_num,
   output logic       reg_write,
   output logic       load_status,
   output logic       asel,
   output logic       bsel,
   output wb_sel_t    wb_sel,
   output mem_cmd_t   mem_cmd,
   output logic       halt
);

   cpu_state_t state;
   cpu_state_t next_state;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_RESET;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = ST_FETCH;
      case (state)
         ST_FETCH, ST_FETCH_LOAD: next_state = ST_UPDATE_PC;
         ST_UPDATE_PC:            next_state = ST_DECODE;
         ST_DECODE: begin
            case (opcode)
               OPC_ALU: begin
                  case (alu_op_t'(op))
                     ALU_ADD: next_state = ST_ADD;
                     ALU_CMP: next_state = ST_CMP;
                     ALU_AND: next_state = ST_AND;
                     default: next_state = ST_NOT;
                  endcase
               end
               OPC_MOVE: begin
                  if (op == MOVE_OP_REG) begin
                     next_state = ST_MOVE_REG;
                  end else if (op == MOVE_OP_IMM) begin
                     next_state = ST_MOVE_IMM;
                  end
               end
               OPC_LOAD, OPC_STORE: next_state = ST_ADDR_CALC;
               OPC_BRANCH:          next_state = ST_BRANCH;
               OPC_LINK: begin
                  if (op == LINK_OP_REG) begin
                     next_state = ST_REG_TO_PC;
                  end else if (op == LINK_OP_REG_LINK || op == LINK_OP_REL) begin
                     next_state = ST_PC_TO_LINK;
                  end
               end
               OPC_HALT: next_state = ST_HALT;
               default:  next_state = ST_FETCH;
            endcase
         end
         ST_ADDR_CALC:  next_state = (opcode == OPC_LOAD) ? ST_LOAD_REG : ST_STORE;
         ST_LOAD_REG:   next_state = ST_FETCH_LOAD;
         ST_PC_TO_LINK: next_state = (op == LINK_OP_REL) ? ST_BRANCH : ST_REG_TO_PC;
         ST_HALT:       next_state = ST_HALT;
         default:       next_state = ST_FETCH;
      endcase
   end

   // Stores and links carry their data or target in Rd
   assign read_a = rn;
   assign read_b = (opcode == OPC_STORE || opcode == OPC_LINK) ? rd : rm;
   assign halt = (state == ST_HALT);

   always_comb begin
      load_ir = 1'b0;
      load_pc = 1'b0;
      reset_pc = 1'b0;
      pc_src = PC_INC;
      load_addr = 1'b0;
      addr_sel = 1'b1;
      write_num = rd;
      reg_write = 1'b0;
      load_status = 1'b0;
      asel = 1'b1;
      bsel = 1'b0;
      wb_sel = WB_ALU;
      mem_cmd = MEM_READ;
      case (state)
         ST_RESET: begin
            reset_pc = 1'b1;
            load_pc = 1'b1;
         end
         ST_FETCH: load_ir = 1'b1;
         ST_FETCH_LOAD: begin
            reg_write = 1'b1;
            wb_sel = WB_MEM;
         end
         ST_UPDATE_PC: begin
            load_ir = 1'b1;
            load_pc = 1'b1;
         end
         // The ALU pass during decode prepares the result used by execute
         ST_DECODE: begin
            if (opcode == OPC_ALU) begin
               asel = 1'b0;
            end else if (opcode == OPC_LOAD || opcode == OPC_STORE) begin
               asel = 1'b0;
               bsel = 1'b1;
            end
         end
         ST_ADD, ST_AND, ST_NOT, ST_MOVE_REG: reg_write = 1'b1;
         ST_CMP: load_status = 1'b1;
         ST_MOVE_IMM: begin
            reg_write = 1'b1;
            write_num = rn;
            wb_sel = WB_IMM;
         end
         ST_ADDR_CALC: load_addr = 1'b1;
         ST_LOAD_REG: addr_sel = 1'b0;
         ST_STORE: begin
            addr_sel = 1'b0;
            mem_cmd = MEM_WRITE;
         end
         ST_PC_TO_LINK: begin
            reg_write = 1'b1;
            write_num = rn;
            wb_sel = WB_PC;
         end
         ST_REG_TO_PC: begin
            load_pc = 1'b1;
            pc_src = take_branch ? PC_ABS : PC_HOLD;
         end
         ST_BRANCH: begin
            load_pc = 1'b1;
            pc_src = take_branch ? PC_REL : PC_HOLD;
         end
         default: begin
         end
      endcase
   end

   a_state_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(state));

   // A write comes only from a store instruction still held in the IR
   a_write_in_store: assert property (@(posedge clk) disable iff (reset)
      (mem_cmd == MEM_WRITE) |-> (state == ST_STORE && opcode == OPC_STORE));

   a_write_or_status: assert property (@(posedge clk) disable iff (reset)
      !(reg_write && load_status));

endmodule

// ==== instruction_decode.sv ====
// Instruction register with field extraction, immediates and branch condition
module instruction_decode import cpu_pkg::*; (
   input  logic       clk,
   input  logic       load_ir,
   input  word_t      read_data,
   input  logic       zero,
   output opcode_t    opcode,
   output logic [1:0] op,
   output alu_op_t    alu_op,
   output reg_idx_t   rn,
   output reg_idx_t   rd,
   output reg_idx_t   rm,
   output word_t      sximm5,
   output word_t      sximm8,
   output logic       take_branch
);

   word_t ir;
   word_t instr;
   logic  cond_met;

   always_ff @(posedge clk) begin
      if (load_ir) begin
         ir <= read_data;
      end
   end

   // Fields follow the incoming word while the IR loads so operands can be read early
   assign instr = load_ir ? read_data : ir;

   assign opcode = opcode_t'(instr[OPC_MSB:OPC_LSB]);
   assign op = instr[OP_MSB:OP_LSB];
   assign rn = instr[RN_MSB:RN_LSB];
   assign rd = instr[RD_MSB:RD_LSB];
   assign rm = instr[RM_MSB:RM_LSB];
   assign sximm5 = {{(DATA_W-IMM5_W){instr[IMM5_W-1]}}, instr[IMM5_W-1:0]};
   assign sximm8 = {{(DATA_W-IMM8_W){instr[IMM8_W-1]}}, instr[IMM8_W-1:0]};

   // Only ALU instructions use the op field as an ALU function
   assign alu_op = (opcode == OPC_ALU) ? alu_op_t'(op) : ALU_ADD;

   always_comb begin
      case (rn)
         COND_ALWAYS: cond_met = 1'b1;
         COND_EQ:     cond_met = zero;
         COND_NE:     cond_met = !zero;
         default:     cond_met = 1'b0;
      endcase
   end

   assign take_branch = (opcode == OPC_LINK) || cond_met;

endmodule

// ==== register_file.sv ====
// Eight-entry register file with one write port and two combinational read ports
module register_file import cpu_pkg::*; #(
   parameter int DATA_W_P = DATA_W
) (
   input  logic                clk,
   input  logic                write,
   input  reg_idx_t            write_num,
   input  logic [DATA_W_P-1:0] write_data,
   input  reg_idx_t            read_a,
   input  reg_idx_t            read_b,
   output logic [DATA_W_P-1:0] data_a,
   output logic [DATA_W_P-1:0] data_b
);

   logic [DATA_W_P-1:0] regs [2**REG_W];

   always_ff @(posedge clk) begin
      if (write) begin
         regs[write_num] <= write_data;
      end
   end

   assign data_a = regs[read_a];
   assign data_b = regs[read_b];

endmodule

// ==== cpu_pkg.sv ====
// Shared widths, instruction fields and encodings for the multicycle CPU core
package cpu_pkg;

   localparam int DATA_W = 16;
   localparam int REG_W = 3;
   localparam int ADDR_W_DEFAULT = 9;

   typedef logic [DATA_W-1:0] word_t;
   typedef logic [REG_W-1:0] reg_idx_t;

   // Instruction field positions
   localparam int OPC_MSB = 15;
   localparam int OPC_LSB = 13;
   localparam int OP_MSB = 12;
   localparam int OP_LSB = 11;
   localparam int RN_MSB = 10;
   localparam int RN_LSB = 8;
   localparam int RD_MSB = 7;
   localparam int RD_LSB = 5;
   localparam int RM_MSB = 2;
   localparam int RM_LSB = 0;
   localparam int IMM8_W = 8;
   localparam int IMM5_W = 5;

   // Branch condition codes carried in the Rn field
   localparam reg_idx_t COND_ALWAYS = 3'd0;
   localparam reg_idx_t COND_EQ = 3'd1;
   localparam reg_idx_t COND_NE = 3'd2;

   // Op field values for moves and link instructions
   localparam logic [1:0] MOVE_OP_REG = 2'd0;
   localparam logic [1:0] MOVE_OP_IMM = 2'd2;
   localparam logic [1:0] LINK_OP_REG = 2'd0;
   localparam logic [1:0] LINK_OP_REG_LINK = 2'd2;
   localparam logic [1:0] LINK_OP_REL = 2'd3;

   typedef enum logic [2:0] {
      OPC_BRANCH = 3'd1,
      OPC_LINK   = 3'd2,
      OPC_LOAD   = 3'd3,
      OPC_STORE  = 3'd4,
      OPC_ALU    = 3'd5,
      OPC_MOVE   = 3'd6,
      OPC_HALT   = 3'd7
   } opcode_t;

   typedef enum logic [1:0] {ALU_ADD, ALU_CMP, ALU_AND, ALU_NOT} alu_op_t;
   typedef enum logic [1:0] {MEM_WRITE = 2'd0, MEM_READ = 2'd1} mem_cmd_t;
   typedef enum logic [1:0] {WB_ALU, WB_PC, WB_IMM, WB_MEM} wb_sel_t;
   typedef enum logic [1:0] {PC_INC, PC_HOLD, PC_REL, PC_ABS} pc_src_t;

   typedef enum logic [4:0] {
      ST_RESET, ST_FETCH, ST_FETCH_LOAD, ST_UPDATE_PC, ST_DECODE,
      ST_ADD, ST_CMP, ST_AND, ST_NOT,
      ST_MOVE_REG, ST_MOVE_IMM,
      ST_ADDR_CALC, ST_LOAD_REG, ST_STORE,
      ST_PC_TO_LINK, ST_REG_TO_PC, ST_BRANCH, ST_HALT
   } cpu_state_t;

endpackage
